//--- hdl/hyper_axi_pkg.sv
// Shared widths, opcodes and channel structs of the HyperBus front end.
// Data width is fixed at 64 bits, so every AXI beat carries 4 words of 16 bits.
// Byte-size transfers and wrapping bursts are outside what the stages handle.
package hyper_axi_pkg;

    localparam int unsigned AddrWidth     = 32;
    localparam int unsigned DataWidth     = 64;
    localparam int unsigned WordsPerBeat  = 4;
    localparam int unsigned LaneWidth     = 2;
    localparam int unsigned BurstLenWidth = 16;

    // AXI burst opcodes
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // Round-robin pointer of the AR/AW arbiter
    typedef enum logic {
        PRIO_READ  = 1'b0,
        PRIO_WRITE = 1'b1
    } arb_prio_e;

    typedef struct packed {
        logic [AddrWidth-1:0] address;
        logic [7:0]           len;
        burst_e               burst;
        logic [2:0]           size;   // log2 bytes per beat, 1 to 3
    } ax_chan_t;

    typedef struct packed {
        logic [DataWidth-1:0]   data;
        logic [DataWidth/8-1:0] strb;
        logic                   last;
    } w_chan_t;

    typedef struct packed {
        logic [DataWidth-1:0] data;
        resp_e                resp;
        logic                 last;
    } r_chan_t;

    // PHY word channels
    typedef struct packed {
        logic [15:0] data;
        logic [1:0]  strb;
        logic        last;
    } hyper_tx_t;

    typedef struct packed {
        logic [15:0] data;
        logic        last;
        logic        error;
    } hyper_rx_t;

    // Transfer command, burst counted in 16-bit words
    typedef struct packed {
        logic                     write;
        logic [BurstLenWidth-1:0] burst;
        logic                     burst_type;
        logic                     address_space;
        logic [AddrWidth-1:0]     address;
    } hyper_tf_t;

    // End address is exclusive
    typedef struct packed {
        logic [AddrWidth-1:0] start_addr;
        logic [AddrWidth-1:0] end_addr;
    } chip_rule_t;

endpackage

//--- hdl/hyper_ax_decode.sv
// AR/AW arbiter and transfer command decode.
// A grant is locked once offered and held until trans_ready_i; address and size
// of the offered channel must stay stable meanwhile. Unmapped addresses go to chip 0.
module hyper_ax_decode #(
    parameter int unsigned NumChips = 1
) (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  hyper_axi_pkg::ax_chan_t                  ar_i,
    input  logic                                     ar_valid_i,
    output logic                                     ar_ready_o,
    input  hyper_axi_pkg::ax_chan_t                  aw_i,
    input  logic                                     aw_valid_i,
    output logic                                     aw_ready_o,
    output hyper_axi_pkg::hyper_tf_t                 trans_o,
    output logic [NumChips-1:0]                      trans_cs_o,
    output logic                                     trans_valid_o,
    input  logic                                     trans_ready_i,
    output logic                                     trans_fire_o,
    input  hyper_axi_pkg::chip_rule_t [NumChips-1:0] chip_rules_i,
    input  logic                                     addr_space_i,
    output logic [2:0]                               curr_size_o,
    output logic [hyper_axi_pkg::LaneWidth-1:0]      start_lane_o
);

    import hyper_axi_pkg::*;

    ax_chan_t                 ax_sel;
    logic                     write_sel;
    arb_prio_e                prio_q;
    logic                     lock_q;
    logic                     lock_write_q;
    logic [2:0]               size_q;
    logic [NumChips-1:0]      rule_hit;
    logic                     cs_found;
    logic [BurstLenWidth-1:0] beat_cnt;

    // A locked grant wins, otherwise the pointer breaks ties
    always_comb begin : proc_arb_select
        if (lock_q) begin
            write_sel = lock_write_q;
        end else if (ar_valid_i && aw_valid_i) begin
            write_sel = (prio_q == PRIO_WRITE);
        end else begin
            write_sel = aw_valid_i;
        end
    end

    assign ax_sel        = write_sel ? aw_i : ar_i;
    assign trans_valid_o = write_sel ? aw_valid_i : ar_valid_i;
    assign ar_ready_o    = trans_ready_i & ~write_sel;
    assign aw_ready_o    = trans_ready_i & write_sel;
    assign trans_fire_o  = trans_valid_o & trans_ready_i;

    // Lane counters load from this while trans_fire_o is high
    assign start_lane_o = ax_sel.address[LaneWidth:1];
    assign curr_size_o  = size_q;

    always_comb begin : proc_chip_match
        for (int unsigned i = 0; i < NumChips; i++) begin
            rule_hit[i] = (ax_sel.address >= chip_rules_i[i].start_addr) &&
                          (ax_sel.address <  chip_rules_i[i].end_addr);
        end
    end

    // Lowest matching rule wins, chip 0 as default
    always_comb begin : proc_chip_onehot
        cs_found   = 1'b0;
        trans_cs_o = '0;
        for (int unsigned i = 0; i < NumChips; i++) begin
            if (!cs_found && rule_hit[i]) begin
                trans_cs_o[i] = 1'b1;
                cs_found      = 1'b1;
            end
        end
        if (!cs_found) begin
            trans_cs_o[0] = 1'b1;
        end
    end

    // PHY expects the undecremented word count
    assign beat_cnt = BurstLenWidth'(ax_sel.len) + 1'b1;

    assign trans_o.write         = write_sel;
    assign trans_o.burst         = beat_cnt << (ax_sel.size - 3'd1);
    assign trans_o.burst_type    = ax_sel.burst[0];
    assign trans_o.address_space = addr_space_i;
    assign trans_o.address       = ax_sel.address;

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_arb_state
        if (!rst_ni) begin
            prio_q       <= PRIO_READ;
            lock_q       <= 1'b0;
            lock_write_q <= 1'b0;
            size_q       <= 3'd1;
        end else if (trans_fire_o) begin
            // Next time prefer the other channel
            prio_q <= write_sel ? PRIO_READ : PRIO_WRITE;
            lock_q <= 1'b0;
            size_q <= ax_sel.size;
        end else if (trans_valid_o) begin
            lock_q       <= 1'b1;
            lock_write_q <= write_sel;
        end
    end

endmodule

//--- hdl/hyper_w_execute.sv
// W beat down-conversion into 16-bit PHY words.
// Size and start lane come from the latest transfer command, so only one
// transfer may be in flight. A W beat is accepted with its final word.
module hyper_w_execute (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  hyper_axi_pkg::w_chan_t              w_i,
    input  logic                                w_valid_i,
    output logic                                w_ready_o,
    output hyper_axi_pkg::hyper_tx_t            tx_o,
    output logic                                tx_valid_o,
    input  logic                                tx_ready_i,
    input  logic                                trans_fire_i,
    input  logic [2:0]                          curr_size_i,
    input  logic [hyper_axi_pkg::LaneWidth-1:0] start_lane_i
);

    import hyper_axi_pkg::*;

    logic [LaneWidth-1:0] lane_q;
    logic                 end_beat;

    // Beat ends when the low size-1 lane bits are all ones
    always_comb begin : proc_end_beat
        end_beat = 1'b1;
        for (int i = 0; i < LaneWidth; i++) begin
            if (i < int'(curr_size_i) - 1) begin
                end_beat &= lane_q[i];
            end
        end
    end

    assign tx_o.data  = w_i.data[16*lane_q +: 16];
    assign tx_o.strb  = w_i.strb[2*lane_q +: 2];
    assign tx_o.last  = w_i.last & end_beat;
    assign tx_valid_o = w_valid_i;
    assign w_ready_o  = tx_ready_i & end_beat;

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_lane_cnt
        if (!rst_ni) begin
            lane_q <= '0;
        end else if (trans_fire_i) begin
            lane_q <= start_lane_i;
        end else if (tx_valid_o && tx_ready_i) begin
            // Wraps around inside the 64-bit beat
            lane_q <= lane_q + 1'b1;
        end
    end

endmodule

//--- hdl/hyper_r_result.sv
// R beat up-conversion from 16-bit PHY words.
// Earlier words of a beat are buffered, the final word is forwarded in the
// same cycle. Any word error of a beat turns its response into SLVERR.
module hyper_r_result (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  hyper_axi_pkg::hyper_rx_t            rx_i,
    input  logic                                rx_valid_i,
    output logic                                rx_ready_o,
    output hyper_axi_pkg::r_chan_t              r_o,
    output logic                                r_valid_o,
    input  logic                                r_ready_i,
    input  logic                                trans_fire_i,
    input  logic [2:0]                          curr_size_i,
    input  logic [hyper_axi_pkg::LaneWidth-1:0] start_lane_i
);

    import hyper_axi_pkg::*;

    logic [LaneWidth-1:0] lane_q;
    logic                 end_beat;
    logic                 rx_take;
    logic [DataWidth-1:0] data_q;
    logic                 err_q;
    logic [DataWidth-1:0] beat_data;

    always_comb begin : proc_end_beat
        end_beat = 1'b1;
        for (int i = 0; i < LaneWidth; i++) begin
            if (i < int'(curr_size_i) - 1) begin
                end_beat &= lane_q[i];
            end
        end
    end

    // Non-final words are always taken into the buffer
    assign rx_ready_o = ~end_beat | r_ready_i;
    assign rx_take    = rx_valid_i & rx_ready_o;
    assign r_valid_o  = rx_valid_i & end_beat;

    always_comb begin : proc_beat_data
        beat_data                    = data_q;
        beat_data[16*lane_q +: 16]   = rx_i.data;
    end

    assign r_o.data = beat_data;
    assign r_o.resp = (err_q | rx_i.error) ? SLVERR : OKAY;
    assign r_o.last = rx_i.last;

    always_ff @(posedge clk_i) begin : proc_buffer
        if (rx_take && !end_beat) begin
            data_q[16*lane_q +: 16] <= rx_i.data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ctrl
        if (!rst_ni) begin
            lane_q <= '0;
            err_q  <= 1'b0;
        end else begin
            if (trans_fire_i) begin
                lane_q <= start_lane_i;
            end else if (rx_take) begin
                lane_q <= lane_q + 1'b1;
            end
            // Sticky until the beat has been handed over
            if (rx_take) begin
                err_q <= end_beat ? 1'b0 : (err_q | rx_i.error);
            end
        end
    end

endmodule

//--- hdl/hyper_axi_frontend.sv
// AXI to HyperBus front end without IDs, atomics or user fields.
// The master must keep one transfer outstanding at a time.
// The B response is passed straight through, a PHY error gives SLVERR.
module hyper_axi_frontend #(
    parameter int unsigned NumChips = 1
) (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    // AXI port
    input  hyper_axi_pkg::ax_chan_t                  ar_i,
    input  logic                                     ar_valid_i,
    output logic                                     ar_ready_o,
    input  hyper_axi_pkg::ax_chan_t                  aw_i,
    input  logic                                     aw_valid_i,
    output logic                                     aw_ready_o,
    input  hyper_axi_pkg::w_chan_t                   w_i,
    input  logic                                     w_valid_i,
    output logic                                     w_ready_o,
    output hyper_axi_pkg::r_chan_t                   r_o,
    output logic                                     r_valid_o,
    input  logic                                     r_ready_i,
    output hyper_axi_pkg::resp_e                     b_o,
    output logic                                     b_valid_o,
    input  logic                                     b_ready_i,
    // PHY port
    output hyper_axi_pkg::hyper_tf_t                 trans_o,
    output logic [NumChips-1:0]                      trans_cs_o,
    output logic                                     trans_valid_o,
    input  logic                                     trans_ready_i,
    output hyper_axi_pkg::hyper_tx_t                 tx_o,
    output logic                                     tx_valid_o,
    input  logic                                     tx_ready_i,
    input  hyper_axi_pkg::hyper_rx_t                 rx_i,
    input  logic                                     rx_valid_i,
    output logic                                     rx_ready_o,
    input  logic                                     b_error_i,
    input  logic                                     b_valid_i,
    output logic                                     b_ready_o,
    // Levels
    input  hyper_axi_pkg::chip_rule_t [NumChips-1:0] chip_rules_i,
    input  logic                                     addr_space_i
);

    import hyper_axi_pkg::*;

    logic                 trans_fire;
    logic [2:0]           curr_size;
    logic [LaneWidth-1:0] start_lane;

    hyper_ax_decode #(
        .NumChips ( NumChips )
    ) i_ax_decode (
        .clk_i, .rst_ni,
        .ar_i, .ar_valid_i, .ar_ready_o,
        .aw_i, .aw_valid_i, .aw_ready_o,
        .trans_o, .trans_cs_o, .trans_valid_o, .trans_ready_i,
        .trans_fire_o ( trans_fire ),
        .chip_rules_i, .addr_space_i,
        .curr_size_o  ( curr_size  ),
        .start_lane_o ( start_lane )
    );

    hyper_w_execute i_w_execute (
        .clk_i, .rst_ni,
        .w_i, .w_valid_i, .w_ready_o,
        .tx_o, .tx_valid_o, .tx_ready_i,
        .trans_fire_i ( trans_fire ),
        .curr_size_i  ( curr_size  ),
        .start_lane_i ( start_lane )
    );

    hyper_r_result i_r_result (
        .clk_i, .rst_ni,
        .rx_i, .rx_valid_i, .rx_ready_o,
        .r_o, .r_valid_o, .r_ready_i,
        .trans_fire_i ( trans_fire ),
        .curr_size_i  ( curr_size  ),
        .start_lane_i ( start_lane )
    );

    // B channel is a 1:1 connection
    assign b_o       = b_error_i ? SLVERR : OKAY;
    assign b_valid_o = b_valid_i;
    assign b_ready_o = b_ready_i;

endmodule

//--- tb/hyper_axi_properties.sv
// Handshake and decode properties of the AR/AW arbiter, bound to hyper_ax_decode.
// All checks are disabled while reset is asserted.
module hyper_axi_properties #(
    parameter int unsigned NumChips = 1
) (
    input logic                     clk_i,
    input logic                     rst_ni,
    input hyper_axi_pkg::hyper_tf_t trans_i,
    input logic [NumChips-1:0]      trans_cs_i,
    input logic                     trans_valid_i,
    input logic                     trans_ready_i,
    input logic                     ar_ready_i,
    input logic                     aw_ready_i
);

    // Offered command holds until the PHY takes it
    valid_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        trans_valid_i && !trans_ready_i |=> trans_valid_i && $stable(trans_i))
        else $error("trans_o dropped or changed before trans_ready_i");

    cs_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot(trans_cs_i))
        else $error("trans_cs_o is not one-hot");

    ready_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ar_ready_i && aw_ready_i))
        else $error("ar_ready_o and aw_ready_o are both high");

endmodule

bind hyper_ax_decode hyper_axi_properties #(
    .NumChips ( NumChips )
) i_properties (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .trans_i       ( trans_o       ),
    .trans_cs_i    ( trans_cs_o    ),
    .trans_valid_i ( trans_valid_o ),
    .trans_ready_i ( trans_ready_i ),
    .ar_ready_i    ( ar_ready_o    ),
    .aw_ready_i    ( aw_ready_o    )
);

//--- tb/hyper_axi_tb.sv
// Self-checking testbench for the HyperBus front end with three chip-select rules.
// Acts as AXI master and PHY at once and keeps one transfer outstanding at a time.
// Inputs change 1 time unit after the rising edge, outputs are sampled at the falling edge.
module hyper_axi_tb;

    import hyper_axi_pkg::*;

    localparam int unsigned NumChips = 3;
    localparam int unsigned Timeout  = 200;

    logic                       clk_i;
    logic                       rst_ni;
    ax_chan_t                   ar_i;
    logic                       ar_valid_i;
    logic                       ar_ready_o;
    ax_chan_t                   aw_i;
    logic                       aw_valid_i;
    logic                       aw_ready_o;
    w_chan_t                    w_i;
    logic                       w_valid_i;
    logic                       w_ready_o;
    r_chan_t                    r_o;
    logic                       r_valid_o;
    logic                       r_ready_i;
    resp_e                      b_o;
    logic                       b_valid_o;
    logic                       b_ready_i;
    hyper_tf_t                  trans_o;
    logic [NumChips-1:0]        trans_cs_o;
    logic                       trans_valid_o;
    logic                       trans_ready_i;
    hyper_tx_t                  tx_o;
    logic                       tx_valid_o;
    logic                       tx_ready_i;
    hyper_rx_t                  rx_i;
    logic                       rx_valid_i;
    logic                       rx_ready_o;
    logic                       b_error_i;
    logic                       b_valid_i;
    logic                       b_ready_o;
    chip_rule_t [NumChips-1:0]  chip_rules_i;
    logic                       addr_space_i;

    logic [31:0] rng_state;
    int unsigned err_cnt;
    int unsigned check_cnt;
    int unsigned test_base;
    // Model of the arbiter pointer
    logic        exp_prio_write;

    hyper_axi_frontend #(
        .NumChips ( NumChips )
    ) uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic random_bit();
        return (next_rand() >= 32'h8000_0000);
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout after %0d cycles while waiting for %s", Timeout, what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic end_test(input string name);
        $display("Test %s finished with %0d errors", name, err_cnt - test_base);
        test_base = err_cnt;
    endtask

    // Aligned random command, sizes 1 to 3, lengths 0 to 7
    function automatic ax_chan_t random_ax();
        ax_chan_t    ax;
        logic [31:0] r;
        r          = next_rand();
        ax.size    = 3'(1 + r[31:24] % 3);
        ax.len     = 8'(r[23:21]);
        ax.burst   = burst_e'((r[20:19] == 2'b11) ? 2'b01 : r[20:19]);
        r          = next_rand();
        ax.address = {6'b0, r[31:6]} & ~((32'd1 << ax.size) - 32'd1);
        return ax;
    endfunction

    function automatic logic [NumChips-1:0] expected_cs(input logic [31:0] addr);
        logic [NumChips-1:0] cs;
        cs = '0;
        // Walk downwards so the lowest matching rule is kept
        for (int i = NumChips - 1; i >= 0; i--) begin
            if (addr >= chip_rules_i[i].start_addr && addr < chip_rules_i[i].end_addr) begin
                cs = NumChips'(1) << i;
            end
        end
        if (cs == '0) begin
            cs = NumChips'(1);
        end
        return cs;
    endfunction

    function automatic hyper_tf_t expected_trans(input ax_chan_t ax, input logic write);
        hyper_tf_t tf;
        tf.write         = write;
        tf.burst         = 16'((int'(ax.len) + 1) << (int'(ax.size) - 1));
        tf.burst_type    = ax.burst[0];
        tf.address_space = addr_space_i;
        tf.address       = ax.address;
        return tf;
    endfunction

    task automatic new_w_beat(input logic last);
        w_i.data = {next_rand(), next_rand()};
        w_i.strb = 8'(next_rand());
        w_i.last = last;
    endtask

    task automatic new_rx_word(input logic last, input logic with_errors);
        rx_i.data  = 16'(next_rand());
        rx_i.last  = last;
        rx_i.error = with_errors && (next_rand() < 32'h4000_0000);
    endtask

    // Offers one command and waits for the PHY to take it
    task automatic issue_command(input ax_chan_t ax, input logic write);
        hyper_tf_t   exp_tf;
        int unsigned cnt;
        logic        done;
        exp_tf = expected_trans(ax, write);
        if (write) begin
            aw_i       = ax;
            aw_valid_i = 1'b1;
        end else begin
            ar_i       = ax;
            ar_valid_i = 1'b1;
        end
        trans_ready_i = random_bit();
        cnt  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk_i);
            compare_value("trans_valid_o", trans_valid_o, 64'd1);
            compare_value("trans_o", trans_o, exp_tf);
            compare_value("trans_cs_o", trans_cs_o, expected_cs(ax.address));
            if (write) begin
                compare_value("aw_ready_o", aw_ready_o, trans_ready_i);
            end else begin
                compare_value("ar_ready_o", ar_ready_o, trans_ready_i);
            end
            done = trans_ready_i;
            @(posedge clk_i);
            #1;
            cnt++;
            trans_ready_i = random_bit();
            if (!done && cnt == Timeout) begin
                abort_run("a transfer command handshake");
            end
        end
        trans_ready_i = 1'b0;
        if (write) begin
            aw_valid_i = 1'b0;
        end else begin
            ar_valid_i = 1'b0;
        end
        exp_prio_write = !write;
    endtask

    task automatic write_test(input int unsigned count);
        ax_chan_t    ax;
        int unsigned nw;
        int unsigned total;
        int unsigned widx;
        int unsigned lane;
        int unsigned cnt;
        logic        fin;
        logic        took;
        for (int t = 0; t < int'(count); t++) begin
            ax           = random_ax();
            addr_space_i = random_bit();
            issue_command(ax, 1'b1);
            nw    = 1 << (ax.size - 1);
            total = (ax.len + 1) * nw;
            widx  = 0;
            cnt   = 0;
            new_w_beat(ax.len == 0);
            w_valid_i  = 1'b1;
            tx_ready_i = random_bit();
            while (widx < total) begin
                @(negedge clk_i);
                lane = (ax.address[2:1] + widx) % 4;
                fin  = (widx % nw) == nw - 1;
                compare_value("tx_valid_o", tx_valid_o, 64'd1);
                compare_value("tx_o.data", tx_o.data, w_i.data[16*lane +: 16]);
                compare_value("tx_o.strb", tx_o.strb, w_i.strb[2*lane +: 2]);
                compare_value("tx_o.last", tx_o.last, fin && (widx / nw == ax.len));
                compare_value("w_ready_o", w_ready_o, fin && tx_ready_i);
                took = tx_ready_i;
                @(posedge clk_i);
                #1;
                if (took) begin
                    widx++;
                    cnt = 0;
                    if (fin) begin
                        new_w_beat(widx / nw == ax.len);
                    end
                end else begin
                    cnt++;
                end
                tx_ready_i = random_bit();
                if (cnt == Timeout) begin
                    abort_run("a PHY write word handshake");
                end
            end
            w_valid_i  = 1'b0;
            tx_ready_i = 1'b0;
        end
    endtask

    task automatic read_test(input int unsigned count, input logic with_errors);
        ax_chan_t    ax;
        int unsigned nw;
        int unsigned total;
        int unsigned widx;
        int unsigned lane;
        int unsigned beats;
        int unsigned r_beats;
        int unsigned cnt;
        logic        fin;
        logic        took;
        logic        beat_err;
        logic [63:0] exp_data;
        logic [63:0] lane_mask;
        logic [63:0] data_now;
        logic [63:0] mask_now;
        for (int t = 0; t < int'(count); t++) begin
            ax           = random_ax();
            addr_space_i = random_bit();
            issue_command(ax, 1'b0);
            nw        = 1 << (ax.size - 1);
            total     = (ax.len + 1) * nw;
            widx      = 0;
            beats     = 0;
            r_beats   = 0;
            cnt       = 0;
            beat_err  = 1'b0;
            exp_data  = '0;
            lane_mask = '0;
            new_rx_word(total == 1, with_errors);
            rx_valid_i = random_bit();
            r_ready_i  = random_bit();
            while (widx < total) begin
                @(negedge clk_i);
                lane = (ax.address[2:1] + widx) % 4;
                fin  = (widx % nw) == nw - 1;
                took = rx_valid_i && (!fin || r_ready_i);
                compare_value("r_valid_o", r_valid_o, rx_valid_i && fin);
                if (rx_valid_i) begin
                    compare_value("rx_ready_o", rx_ready_o, !fin || r_ready_i);
                end
                if (rx_valid_i && fin) begin
                    // Only the lanes of this beat carry data
                    data_now = exp_data;
                    data_now[16*lane +: 16] = rx_i.data;
                    mask_now = lane_mask;
                    mask_now[16*lane +: 16] = '1;
                    compare_value("r_o.data", r_o.data & mask_now, data_now);
                    compare_value("r_o.resp", r_o.resp,
                                  (beat_err || rx_i.error) ? SLVERR : OKAY);
                    compare_value("r_o.last", r_o.last, beats == ax.len);
                end
                // R handshakes as seen on the DUT side
                if (r_valid_o && r_ready_i) begin
                    r_beats++;
                end
                @(posedge clk_i);
                #1;
                if (took) begin
                    if (fin) begin
                        beats++;
                        exp_data  = '0;
                        lane_mask = '0;
                        beat_err  = 1'b0;
                    end else begin
                        exp_data[16*lane +: 16]  = rx_i.data;
                        lane_mask[16*lane +: 16] = '1;
                        beat_err = beat_err | rx_i.error;
                    end
                    widx++;
                    cnt = 0;
                    new_rx_word(widx == total - 1, with_errors);
                    rx_valid_i = random_bit();
                end else begin
                    cnt++;
                    rx_valid_i = rx_valid_i | random_bit();
                end
                r_ready_i = random_bit();
                if (cnt == Timeout) begin
                    abort_run("a PHY read word or R beat handshake");
                end
            end
            rx_valid_i = 1'b0;
            r_ready_i  = 1'b0;
            compare_value("R beat count", r_beats, ax.len + 1);
        end
    endtask

    task automatic command_test(input int unsigned count);
        for (int t = 0; t < int'(count); t++) begin
            addr_space_i = random_bit();
            issue_command(random_ax(), random_bit());
        end
    endtask

    // Both channels stay pending, served ones come back with a new command
    task automatic arbitration_test(input int unsigned count);
        ax_chan_t rd;
        ax_chan_t wr;
        rd         = random_ax();
        wr         = random_ax();
        ar_i       = rd;
        aw_i       = wr;
        ar_valid_i = 1'b1;
        aw_valid_i = 1'b1;
        for (int n = 0; n < int'(count); n++) begin
            if (exp_prio_write) begin
                issue_command(wr, 1'b1);
                wr         = random_ax();
                aw_i       = wr;
                aw_valid_i = 1'b1;
            end else begin
                issue_command(rd, 1'b0);
                rd         = random_ax();
                ar_i       = rd;
                ar_valid_i = 1'b1;
            end
        end
        ar_valid_i = 1'b0;
        aw_valid_i = 1'b0;
    endtask

    task automatic b_test(input int unsigned count);
        for (int n = 0; n < int'(count); n++) begin
            b_error_i = random_bit();
            b_valid_i = random_bit();
            b_ready_i = random_bit();
            @(negedge clk_i);
            compare_value("b_o", b_o, b_error_i ? SLVERR : OKAY);
            compare_value("b_valid_o", b_valid_o, b_valid_i);
            compare_value("b_ready_o", b_ready_o, b_ready_i);
            @(posedge clk_i);
            #1;
        end
    endtask

    initial begin
        rng_state      = 32'he02a88e2;
        err_cnt        = 0;
        check_cnt      = 0;
        test_base      = 0;
        exp_prio_write = 1'b0;
        rst_ni         = 1'b0;
        ar_i           = '0;
        ar_valid_i     = 1'b0;
        aw_i           = '0;
        aw_valid_i     = 1'b0;
        w_i            = '0;
        w_valid_i      = 1'b0;
        r_ready_i      = 1'b0;
        b_ready_i      = 1'b0;
        trans_ready_i  = 1'b0;
        tx_ready_i     = 1'b0;
        rx_i           = '0;
        rx_valid_i     = 1'b0;
        b_error_i      = 1'b0;
        b_valid_i      = 1'b0;
        addr_space_i   = 1'b0;
        // Rules 1 and 2 overlap, the top quarter of the range is unmapped
        chip_rules_i[0] = '{start_addr: 32'h0000_0000, end_addr: 32'h0100_0000};
        chip_rules_i[1] = '{start_addr: 32'h0100_0000, end_addr: 32'h0200_0000};
        chip_rules_i[2] = '{start_addr: 32'h0180_0000, end_addr: 32'h0300_0000};
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(posedge clk_i);
        #1;
        write_test(30);
        end_test("write down-conversion");
        read_test(30, 1'b0);
        end_test("read up-conversion");
        read_test(30, 1'b1);
        end_test("read error folding");
        command_test(40);
        end_test("transfer command");
        arbitration_test(12);
        end_test("arbitration");
        b_test(50);
        end_test("B passthrough");
        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/hyper_axi_pkg.sv
hdl/hyper_ax_decode.sv
hdl/hyper_w_execute.sv
hdl/hyper_r_result.sv
hdl/hyper_axi_frontend.sv
tb/hyper_axi_properties.sv
tb/hyper_axi_tb.sv

//--- Makefile
# Verilator build and regression run of the HyperBus front end

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module hyper_axi_tb -Mdir obj_dir
	./obj_dir/Vhyper_axi_tb | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
